/* run_sim.sh */
#!/usr/bin/env bash
# compile the fetch testbench with Verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f tb.f --top-module fetch_tb -Mdir obj_dir -o fetch_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
   cat "$BUILD_LOG"
   echo "verilator build failed"
   exit 1
fi

./obj_dir/fetch_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Test FAILED" "$SIM_LOG"; then
   exit 1
fi
exit 0

/* tb.f */
+incdir+verilog
verilog/ifu_pkg.sv
verilog/ifu_rd_if.sv
verilog/pc_gen.sv
verilog/fetch_ctrl.sv
verilog/inst_out.sv
verilog/imem_model.sv
verilog/fetch_top.sv
test/fetch_checker.sv
test/fetch_tb.sv

/* test/fetch_checker.sv */
`timescale 1ns/1ps
`include "ifu_defines.svh"

module fetch_checker (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 inst_valid,
   input  logic [31:0]          inst,
   input  logic [`IFU_XLEN-1:0] inst_pc,
   input  logic                 inst_fault,
   input  logic [`IFU_XLEN-1:0] fetch_pc,
   output logic                 seen_valid,
   output logic [`IFU_XLEN-1:0] seen_pc,
   output int                   checked,
   output int                   tests_pass,
   output int                   tests_fail,
   output int                   errors
);

   // expected stream, one entry per delivery
   logic [`IFU_XLEN-1:0] exp_pc [$];
   logic [31:0]          exp_inst [$];
   logic                 exp_fault [$];
   int                   exp_test [$];
   // per test tallies
   int                   test_err;
   int                   test_cnt;
   logic                 prev_valid;

   initial begin
      checked    = 0;
      tests_pass = 0;
      tests_fail = 0;
      errors     = 0;
      test_err   = 0;
      test_cnt   = 0;
      prev_valid = 1'b0;
      seen_valid = 1'b0;
      seen_pc    = '0;
   end

   task automatic add_expect(input logic [`IFU_XLEN-1:0] pc, input logic [31:0] word,
                             input logic fault, input int test);
      exp_pc.push_back(pc);
      exp_inst.push_back(word);
      exp_fault.push_back(fault);
      exp_test.push_back(test);
   endtask

   task automatic close_test(input int test);
      if (test_err == 0) begin
         tests_pass++;
         $display("test %0d: %0d instructions, passed", test, test_cnt);
      end else begin
         tests_fail++;
         $display("test %0d: %0d instructions, %0d mismatches, failed",
                  test, test_cnt, test_err);
      end
      test_err = 0;
      test_cnt = 0;
   endtask

   task automatic compare_one();
      int                   test;
      logic [`IFU_XLEN-1:0] next_pc;
      if (exp_pc.size() == 0) begin
         $display("[ERROR] %0t: delivery at pc %h with nothing expected", $time, inst_pc);
         errors++;
      end else begin
         test = exp_test[0];
         // fetch pc has already stepped one instruction past the delivery
         next_pc = exp_pc[0] + `IFU_XLEN'd4;
         test_cnt++;
         if (inst_pc !== exp_pc[0] || inst !== exp_inst[0] || inst_fault !== exp_fault[0]) begin
            $display(
               "[ERROR] %0t: test %0d expected pc %h inst %h fault %b, got pc %h inst %h fault %b",
               $time, test, exp_pc[0], exp_inst[0], exp_fault[0], inst_pc, inst, inst_fault);
            test_err++;
            errors++;
         end
         if (fetch_pc !== next_pc) begin
            $display("[ERROR] %0t: test %0d fetch pc after %h expected %h, got %h",
                     $time, test, exp_pc[0], next_pc, fetch_pc);
            test_err++;
            errors++;
         end
         void'(exp_pc.pop_front());
         void'(exp_inst.pop_front());
         void'(exp_fault.pop_front());
         void'(exp_test.pop_front());
         checked++;
         // last entry of this test just went
         if (exp_test.size() == 0 || exp_test[0] != test) begin
            close_test(test);
         end
      end
   endtask

   always @(posedge clk) begin
      // registered copy for the redirect driver
      seen_valid <= inst_valid;
      seen_pc    <= inst_pc;
      prev_valid <= inst_valid;
      if (!rst_n) begin
         if (inst_valid === 1'b1 || inst_fault === 1'b1) begin
            $display("inst_valid or inst_fault was high during reset at %0t", $time);
            errors++;
         end
      end else if (inst_valid) begin
         // one cycle pulse per fetch
         if (prev_valid) begin
            $display("inst_valid stayed high for two cycles at %0t", $time);
            errors++;
         end
         compare_one();
      end
   end

endmodule

/* test/fetch_tb.sv */
`timescale 1ns/1ps
`include "ifu_defines.svh"

module fetch_tb;

   logic                   clk;
   logic                   rst_n;
   logic [`IFU_XLEN-1:0]   dnpc;
   logic                   pc_update;
   logic                   load_en;
   logic [`IFU_ADDR_W-1:0] load_addr;
   logic [`IFU_XLEN-1:0]   load_data;
   logic [`IFU_XLEN-1:0]   pc;
   logic [31:0]            inst;
   logic [`IFU_XLEN-1:0]   inst_pc;
   logic                   inst_valid;
   logic                   inst_fault;
   logic                   seen_valid;
   logic [`IFU_XLEN-1:0]   seen_pc;
   int                     checked;
   int                     tests_pass;
   int                     tests_fail;
   int                     errors;

   // program image and redirect commands from the trace
   logic [`IFU_ADDR_W-1:0] img_addr [$];
   logic [`IFU_XLEN-1:0]   img_data [$];
   logic [`IFU_XLEN-1:0]   rd_trig [$];
   logic [`IFU_XLEN-1:0]   rd_tgt [$];
   int                     total;
   int                     cycles;
   int                     limit;
   bit                     trace_ok;

   fetch_top u_fetch_top (
      .clk        (clk),
      .rst_n      (rst_n),
      .dnpc       (dnpc),
      .pc_update  (pc_update),
      .load_en    (load_en),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .pc         (pc),
      .inst       (inst),
      .inst_pc    (inst_pc),
      .inst_valid (inst_valid),
      .inst_fault (inst_fault)
   );

   fetch_checker u_checker (
      .clk        (clk),
      .rst_n      (rst_n),
      .inst_valid (inst_valid),
      .inst       (inst),
      .inst_pc    (inst_pc),
      .inst_fault (inst_fault),
      .fetch_pc   (pc),
      .seen_valid (seen_valid),
      .seen_pc    (seen_pc),
      .checked    (checked),
      .tests_pass (tests_pass),
      .tests_fail (tests_fail),
      .errors     (errors)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic read_trace();
      int                     fd;
      int                     n;
      int                     test_id;
      logic [7:0]             kind;
      logic [8*128-1:0]       rest;
      logic [`IFU_ADDR_W-1:0] addr;
      logic [`IFU_XLEN-1:0]   v0;
      logic [`IFU_XLEN-1:0]   v1;
      logic [31:0]            word;
      logic                   fault;
      fd = $fopen("test/fetch_trace.txt", "r");
      trace_ok = (fd != 0);
      test_id = 0;
      while (trace_ok && $fscanf(fd, "%s", kind) == 1) begin
         case (kind)
            "#": begin
               n = $fgets(rest, fd);
            end
            "L": begin
               n = $fscanf(fd, "%h %h", addr, v0);
               img_addr.push_back(addr);
               img_data.push_back(v0);
               if (n != 2) trace_ok = 1'b0;
            end
            "T": begin
               n = $fscanf(fd, "%d", test_id);
               if (n != 1) trace_ok = 1'b0;
            end
            "R": begin
               n = $fscanf(fd, "%h %h", v0, v1);
               rd_trig.push_back(v0);
               rd_tgt.push_back(v1);
               if (n != 2) trace_ok = 1'b0;
            end
            "E": begin
               n = $fscanf(fd, "%h %h %b", v0, word, fault);
               u_checker.add_expect(v0, word, fault, test_id);
               total++;
               if (n != 3) trace_ok = 1'b0;
            end
            default: begin
               trace_ok = 1'b0;
            end
         endcase
      end
      if (fd != 0) $fclose(fd);
      if (total == 0) trace_ok = 1'b0;
   endtask

   // one word per cycle, still under reset
   task automatic load_program();
      foreach (img_addr[i]) begin
         @(posedge clk);
         #1;
         load_en   = 1'b1;
         load_addr = img_addr[i];
         load_data = img_data[i];
      end
      @(posedge clk);
      #1;
      load_en = 1'b0;
   endtask

   // redirect right after the trigger pc shows up at the output
   task automatic run_fetch();
      int head;
      head = 0;
      cycles = 0;
      while (checked < total && cycles < limit) begin
         @(posedge clk);
         #1;
         cycles++;
         if (head < rd_trig.size() && seen_valid && seen_pc == rd_trig[head]) begin
            pc_update = 1'b1;
            dnpc      = rd_tgt[head];
            head++;
         end else begin
            pc_update = 1'b0;
         end
      end
      pc_update = 1'b0;
   endtask

   initial begin
      rst_n     = 1'b0;
      dnpc      = '0;
      pc_update = 1'b0;
      load_en   = 1'b0;
      load_addr = '0;
      load_data = '0;
      total     = 0;
      cycles    = 0;
      read_trace();
      // worst case per fetch is idle + two full memory waits
      limit = total * (2 * `IFU_MAX_LAT + 4) + 100;
      if (trace_ok) begin
         load_program();
         repeat (4) @(posedge clk);
         #1;
         rst_n = 1'b1;
         run_fetch();
      end else begin
         $display("could not read a valid trace from test/fetch_trace.txt");
      end
      if (trace_ok && cycles >= limit) begin
         $display("run timed out after %0d cycles, %0d of %0d instructions delivered",
                  cycles, checked, total);
      end
      $display("tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, errors);
      if (trace_ok && checked == total && tests_fail == 0 && errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

/* test/fetch_trace.txt */
# L addr data : load 64-bit word, upper half is the instruction at addr+4
# T id : start of test, R trigger_pc target_pc : redirect once trigger is delivered
# E pc inst fault : expected delivery, in order
L 80000000 0020011300100093
L 80000008 0040021300300193
L 80000010 0060031300500293
L 80000018 0080041300700393
L 80000020 00a0051300900493
L 80000028 00c0061300b00593
L 80000030 00e0071300d00693
L 80000038 0100081300f00793
L 80000040 0120091301100893
L 80000048 01400a1301300993
L 80000100 00b080938badf0b7
R 80000014 80000100
R 80000104 80001000
R 80001000 80000000
T 1
E 80000000 00100093 0
E 80000004 00200113 0
E 80000008 00300193 0
T 2
E 8000000c 00400213 0
E 80000010 00500293 0
E 80000014 00600313 0
T 3
E 80000100 8badf0b7 0
E 80000104 00b08093 0
T 4
E 80001000 00000000 1
T 5
E 80000000 00100093 0
E 80000004 00200113 0
E 80000008 00300193 0
E 8000000c 00400213 0
E 80000010 00500293 0
E 80000014 00600313 0
E 80000018 00700393 0
E 8000001c 00800413 0
E 80000020 00900493 0
E 80000024 00a00513 0
E 80000028 00b00593 0
E 8000002c 00c00613 0
E 80000030 00d00693 0
E 80000034 00e00713 0
E 80000038 00f00793 0
E 8000003c 01000813 0
E 80000040 01100893 0
E 80000044 01200913 0
E 80000048 01300993 0
E 8000004c 01400a13 0

/* verilog/fetch_ctrl.sv */
`timescale 1ns/1ps
`include "ifu_defines.svh"

module fetch_ctrl (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [`IFU_XLEN-1:0] pc,
   input  logic                 redirect,
   output logic                 advance,
   ifu_rd_if.master             bus,
   output logic                 beat_valid,
   output logic [`IFU_XLEN-1:0] beat_data,
   output logic                 beat_err,
   output logic [`IFU_XLEN-1:0] beat_pc
);

   ifu_pkg::fetch_state_e state;
   ifu_pkg::fetch_state_e state_nxt;

   // pc the outstanding read was issued for
   logic [`IFU_XLEN-1:0] issue_pc;
   // read in flight belongs to a pc that was redirected away
   logic                 stale;
   logic                 ar_fire;
   logic                 r_fire;
   logic                 drop;

   assign ar_fire = bus.arvalid && bus.arready;
   assign r_fire  = bus.rvalid && bus.rready;

   // a redirect landing on the beat cycle also kills that beat
   assign drop = stale || redirect;

   always_comb begin
      state_nxt = state;
      case (state)
         ifu_pkg::fs_idle: begin
            state_nxt = ifu_pkg::fs_addr;
         end
         ifu_pkg::fs_addr: begin
            if (ar_fire) begin
               state_nxt = ifu_pkg::fs_data;
            end
         end
         ifu_pkg::fs_data: begin
            if (r_fire) begin
               state_nxt = ifu_pkg::fs_idle;
            end
         end
         default: begin
            state_nxt = ifu_pkg::fs_idle;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ifu_pkg::fs_idle;
         stale <= 1'b0;
      end else begin
         state <= state_nxt;
         // beat consumed, stale or not, so start clean
         if (state == ifu_pkg::fs_data && r_fire) begin
            stale <= 1'b0;
         end else if (redirect && state != ifu_pkg::fs_idle) begin
            stale <= 1'b1;
         end
      end
   end

   // idle samples the pc, already advanced or redirected by then
   always_ff @(posedge clk) begin
      if (state == ifu_pkg::fs_idle) begin
         issue_pc <= pc;
      end
   end

   // bus side
   assign bus.arvalid = (state == ifu_pkg::fs_addr);
   assign bus.araddr  = issue_pc[`IFU_ADDR_W-1:0];
   // always ready for the beat
   assign bus.rready  = 1'b1;

   // only live beats move the pc and reach the output stage
   assign beat_valid = (state == ifu_pkg::fs_data) && r_fire && !drop;
   assign advance    = beat_valid;
   assign beat_data  = bus.rdata;
   assign beat_err   = (bus.rresp == ifu_pkg::resp_err);
   assign beat_pc    = issue_pc;

   // no beat while the address is still on offer
   a_no_beat_addr : assert property (
      @(posedge clk) disable iff (!rst_n)
      (state == ifu_pkg::fs_addr) |-> !bus.rvalid
   ) else $error("fetch_ctrl: read beat arrived before the address was accepted");

   // the memory answers only after an address was accepted
   a_no_beat_idle : assert property (
      @(posedge clk) disable iff (!rst_n)
      (state == ifu_pkg::fs_idle) |-> !r_fire
   ) else $error("fetch_ctrl: read beat taken with no read outstanding");

endmodule

/* verilog/fetch_top.sv */
`timescale 1ns/1ps
`include "ifu_defines.svh"

module fetch_top (
   input  logic                   clk,
   input  logic                   rst_n,
   // redirect from the core
   input  logic [`IFU_XLEN-1:0]   dnpc,
   input  logic                   pc_update,
   // memory load port
   input  logic                   load_en,
   input  logic [`IFU_ADDR_W-1:0] load_addr,
   input  logic [`IFU_XLEN-1:0]   load_data,
   // fetch results
   output logic [`IFU_XLEN-1:0]   pc,
   output logic [31:0]            inst,
   output logic [`IFU_XLEN-1:0]   inst_pc,
   output logic                   inst_valid,
   output logic                   inst_fault
);

   logic                 redirect;
   logic                 advance;
   logic                 beat_valid;
   logic [`IFU_XLEN-1:0] beat_data;
   logic                 beat_err;
   logic [`IFU_XLEN-1:0] beat_pc;

   // fetch to memory read channel
   ifu_rd_if rd_bus ();

   pc_gen u_pc_gen (
      .clk       (clk),
      .rst_n     (rst_n),
      .dnpc      (dnpc),
      .pc_update (pc_update),
      .advance   (advance),
      .pc        (pc),
      .redirect  (redirect)
   );

   fetch_ctrl u_fetch_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .pc         (pc),
      .redirect   (redirect),
      .advance    (advance),
      .bus        (rd_bus.master),
      .beat_valid (beat_valid),
      .beat_data  (beat_data),
      .beat_err   (beat_err),
      .beat_pc    (beat_pc)
   );

   inst_out u_inst_out (
      .clk        (clk),
      .rst_n      (rst_n),
      .beat_valid (beat_valid),
      .beat_data  (beat_data),
      .beat_err   (beat_err),
      .beat_pc    (beat_pc),
      .inst       (inst),
      .inst_pc    (inst_pc),
      .inst_valid (inst_valid),
      .inst_fault (inst_fault)
   );

   imem_model u_imem_model (
      .clk       (clk),
      .rst_n     (rst_n),
      .bus       (rd_bus.slave),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data)
   );

endmodule

/* verilog/ifu_defines.svh */
`ifndef IFU_DEFINES_SVH
`define IFU_DEFINES_SVH

// first fetch address out of reset
`define IFU_RESET_PC 64'h0000_0000_8000_0000

// pc and read beat width
`define IFU_XLEN 64

// read address width on the bus
`define IFU_ADDR_W 32

// 64-bit words behind the memory, counted from the reset pc
`define IFU_MEM_WORDS 256

// worst case wait cycles before arready, and again before rvalid
`define IFU_MAX_LAT 3

`endif

/* verilog/ifu_pkg.sv */
package ifu_pkg;

   // fetch controller states
   // idle  one cycle between beats, latches the next pc
   // addr  arvalid up, waiting for arready
   // data  address taken, waiting for the beat
   typedef enum logic [1:0] {
      fs_idle = 2'd0,
      fs_addr = 2'd1,
      fs_data = 2'd2
   } fetch_state_e;

   // read response kinds
   // err comes back for addresses outside the memory
   typedef enum logic {
      resp_okay = 1'b0,
      resp_err  = 1'b1
   } rd_resp_e;

endpackage

/* verilog/ifu_rd_if.sv */
`timescale 1ns/1ps
`include "ifu_defines.svh"

interface ifu_rd_if;

   // address channel
   logic                   arvalid;
   logic [`IFU_ADDR_W-1:0] araddr;
   logic                   arready;

   // read channel, one 64-bit beat per address
   logic                   rvalid;
   logic [`IFU_XLEN-1:0]   rdata;
   ifu_pkg::rd_resp_e      rresp;
   logic                   rready;

   // fetch side
   modport master (
      output arvalid,
      output araddr,
      input  arready,
      input  rvalid,
      input  rdata,
      input  rresp,
      output rready
   );

   // memory side
   modport slave (
      input  arvalid,
      input  araddr,
      output arready,
      output rvalid,
      output rdata,
      output rresp,
      input  rready
   );

endinterface

/* verilog/imem_model.sv */
`timescale 1ns/1ps
`include "ifu_defines.svh"

module imem_model (
   input  logic                   clk,
   input  logic                   rst_n,
   ifu_rd_if.slave                bus,
   input  logic                   load_en,
   input  logic [`IFU_ADDR_W-1:0] load_addr,
   input  logic [`IFU_XLEN-1:0]   load_data
);

   localparam int idx_w = $clog2(`IFU_MEM_WORDS);
   localparam int lat_w = $clog2(`IFU_MAX_LAT + 2);
   // memory window starts at the reset pc
   localparam logic [`IFU_ADDR_W-1:0] mem_base  = `IFU_ADDR_W'(`IFU_RESET_PC);
   localparam logic [`IFU_ADDR_W-1:0] mem_bytes = `IFU_ADDR_W'(`IFU_MEM_WORDS * 8);

   logic [`IFU_XLEN-1:0]   mem [0:`IFU_MEM_WORDS-1];
   logic [7:0]             lfsr;
   // address taken, beat not yet delivered
   logic                   pend;
   logic [lat_w-1:0]       ar_cnt;
   logic [lat_w-1:0]       ar_wait;
   logic [lat_w-1:0]       r_cnt;
   logic [lat_w-1:0]       r_wait;
   logic [`IFU_ADDR_W-1:0] r_addr;
   logic [`IFU_ADDR_W-1:0] r_off;
   logic [`IFU_ADDR_W-1:0] load_off;
   logic                   r_hit;
   logic                   load_hit;
   logic                   ar_fire;
   logic                   r_fire;

   // offsets wrap below the base, so one compare covers both ends
   assign r_off    = r_addr - mem_base;
   assign load_off = load_addr - mem_base;
   assign r_hit    = r_off < mem_bytes;
   assign load_hit = load_off < mem_bytes;

   assign ar_fire = bus.arvalid && bus.arready;
   assign r_fire  = bus.rvalid && bus.rready;

   // one read at a time, arready held off while a beat is pending
   assign bus.arready = bus.arvalid && !pend && (ar_cnt >= ar_wait);
   assign bus.rvalid  = pend && (r_cnt >= r_wait);
   assign bus.rdata   = r_hit ? mem[r_off[3 +: idx_w]] : '0;
   assign bus.rresp   = r_hit ? ifu_pkg::resp_okay : ifu_pkg::resp_err;

   // program load from the testbench, word granular
   always_ff @(posedge clk) begin
      if (load_en && load_hit) begin
         mem[load_off[3 +: idx_w]] <= load_data;
      end
   end

   always_ff @(posedge clk) begin
      if (ar_fire) begin
         r_addr <= bus.araddr;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lfsr    <= 8'ha5;
         pend    <= 1'b0;
         ar_cnt  <= '0;
         ar_wait <= '0;
         r_cnt   <= '0;
         r_wait  <= '0;
      end else begin
         // x^8 + x^6 + x^5 + x^4 + 1
         lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
         if (ar_fire) begin
            pend    <= 1'b1;
            ar_cnt  <= '0;
            r_cnt   <= '0;
            // fresh waits for this beat and for the next address
            r_wait  <= lat_w'(lfsr[7:4] % (`IFU_MAX_LAT + 1));
            ar_wait <= lat_w'(lfsr[3:0] % (`IFU_MAX_LAT + 1));
         end else begin
            if (bus.arvalid && !pend && !bus.arready) begin
               ar_cnt <= ar_cnt + 1'b1;
            end
            if (r_fire) begin
               pend <= 1'b0;
            end else if (pend && !bus.rvalid) begin
               r_cnt <= r_cnt + 1'b1;
            end
         end
      end
   end

endmodule

/* verilog/inst_out.sv */
`timescale 1ns/1ps
`include "ifu_defines.svh"

module inst_out (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 beat_valid,
   input  logic [`IFU_XLEN-1:0] beat_data,
   input  logic                 beat_err,
   input  logic [`IFU_XLEN-1:0] beat_pc,
   output logic [31:0]          inst,
   output logic [`IFU_XLEN-1:0] inst_pc,
   output logic                 inst_valid,
   output logic                 inst_fault
);

   // instruction picked out of the beat
   logic [31:0] inst_sel;

   // pc bit 2 picks the half of the 64-bit word
   // faulted fetch returns zero
   always_comb begin
      if (beat_err) begin
         inst_sel = 32'h0;
      end else if (beat_pc[2]) begin
         inst_sel = beat_data[`IFU_XLEN-1:`IFU_XLEN/2];
      end else begin
         inst_sel = beat_data[`IFU_XLEN/2-1:0];
      end
   end

   // strobe and fault flag
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         inst_valid <= 1'b0;
         inst_fault <= 1'b0;
      end else begin
         // single cycle pulse per live beat
         inst_valid <= beat_valid;
         if (beat_valid) begin
            inst_fault <= beat_err;
         end
      end
   end

   // instruction and its pc, held until the next beat
   always_ff @(posedge clk) begin
      if (beat_valid) begin
         inst    <= inst_sel;
         inst_pc <= beat_pc;
      end
   end

endmodule

/* verilog/pc_gen.sv */
`timescale 1ns/1ps
`include "ifu_defines.svh"

module pc_gen (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [`IFU_XLEN-1:0] dnpc,
   input  logic                 pc_update,
   input  logic                 advance,
   output logic [`IFU_XLEN-1:0] pc,
   output logic                 redirect
);

   // next pc
   // a redirect from the core beats the sequential step
   logic [`IFU_XLEN-1:0] pc_nxt;

   always_comb begin
      pc_nxt = pc;
      if (pc_update) begin
         pc_nxt = dnpc;
      end else if (advance) begin
         // fixed 4-byte instructions, no compressed
         pc_nxt = pc + `IFU_XLEN'd4;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc       <= `IFU_RESET_PC;
         redirect <= 1'b0;
      end else begin
         pc       <= pc_nxt;
         // high in the same cycle the new pc shows up
         // lets the controller drop whatever read is in flight
         redirect <= pc_update;
      end
   end

   // targets from the core must be word aligned
   // otherwise the half select downstream picks the wrong word
   a_dnpc_aligned : assert property (
      @(posedge clk) disable iff (!rst_n)
      pc_update |-> (dnpc[1:0] == 2'b00)
   ) else $error("pc_gen: misaligned redirect target %h", dnpc);

endmodule
